/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_network_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axis_if.sv */
// AXI-stream interface
// Master drives data, keep, last and valid; slave drives ready

`timescale 1ns/1ns
`default_nettype none

interface axis_if;

    logic [net_pkg::net_data_bits-1:0] tdata;
    logic [net_pkg::net_keep_bits-1:0] tkeep;
    logic                              tlast;
    logic                              tvalid;
    logic                              tready;

    modport m (
        output tdata, tkeep, tlast, tvalid,
        input  tready
    );

    modport s (
        input  tdata, tkeep, tlast, tvalid,
        output tready
    );

endinterface

`default_nettype wire

/* axis_reg_slice.sv */
// Stream register slice
// Two-entry skid buffer, registered valid/data out and registered ready in

`timescale 1ns/1ns
`default_nettype none

module axis_reg_slice (
    input  logic aclk,
    input  logic aresetn,
    axis_if.s    s,
    axis_if.m    m
);

    localparam int beat_bits = net_pkg::net_data_bits + net_pkg::net_keep_bits + 1;

    logic [beat_bits-1:0] out_beat;
    logic [beat_bits-1:0] skid_beat;
    logic                 out_valid;
    logic                 skid_valid;
    logic                 out_load;

    // Output stage can take a new beat when empty or drained this cycle
    assign out_load = m.tready || !out_valid;

    // Ready comes straight from a flop
    assign s.tready = !skid_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            // Skid entry first, otherwise the incoming beat
            out_valid  <= skid_valid || s.tvalid;
            skid_valid <= 1'b0;
        end else if (s.tvalid && !skid_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (out_load) begin
            out_beat <= skid_valid ? skid_beat : {s.tdata, s.tkeep, s.tlast};
        end
        // Park the beat accepted while the output is stalled
        if (!out_load && !skid_valid) begin
            skid_beat <= {s.tdata, s.tkeep, s.tlast};
        end
    end

    assign {m.tdata, m.tkeep, m.tlast} = out_beat;
    assign m.tvalid = out_valid;

endmodule

`default_nettype wire

/* axis_slice_array.sv */
// Chain of stream register slices
// Latency of n_reg_stages cycles, plain wiring when the count is zero

`timescale 1ns/1ns
`default_nettype none

module axis_slice_array #(
    parameter int n_reg_stages = 2
) (
    input  logic aclk,
    input  logic aresetn,
    axis_if.s    s,
    axis_if.m    m
);

    if (n_reg_stages == 0) begin : g_bypass
        assign m.tdata  = s.tdata;
        assign m.tkeep  = s.tkeep;
        assign m.tlast  = s.tlast;
        assign m.tvalid = s.tvalid;
        assign s.tready = m.tready;
    end else begin : g_chain
        axis_if stage [n_reg_stages+1] ();

        // Chain input
        assign stage[0].tdata  = s.tdata;
        assign stage[0].tkeep  = s.tkeep;
        assign stage[0].tlast  = s.tlast;
        assign stage[0].tvalid = s.tvalid;
        assign s.tready        = stage[0].tready;

        for (genvar i = 0; i < n_reg_stages; i++) begin : g_stage
            axis_reg_slice inst_slice (
                .aclk   (aclk),
                .aresetn(aresetn),
                .s      (stage[i]),
                .m      (stage[i+1])
            );
        end

        // Chain output
        assign m.tdata  = stage[n_reg_stages].tdata;
        assign m.tkeep  = stage[n_reg_stages].tkeep;
        assign m.tlast  = stage[n_reg_stages].tlast;
        assign m.tvalid = stage[n_reg_stages].tvalid;
        assign stage[n_reg_stages].tready = m.tready;
    end

endmodule

`default_nettype wire

/* list.f */
net_pkg.sv
axis_if.sv
axis_reg_slice.sv
axis_slice_array.sv
packet_dropper.sv
mem_cmd_offset.sv
network_top.sv
tb_network_top.sv

/* mem_cmd_offset.sv */
// Memory command offset stage
// Adds a delayed DDR offset to each command address, one output register

`timescale 1ns/1ns
`default_nettype none

module mem_cmd_offset #(
    parameter int n_reg_stages = 2
) (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic [net_pkg::ddr_addr_bits-1:0] offset_addr,
    input  net_pkg::mem_cmd_t                 s_cmd,
    input  logic                              s_cmd_valid,
    output logic                              s_cmd_ready,
    output net_pkg::mem_cmd_t                 m_cmd,
    output logic                              m_cmd_valid,
    input  logic                              m_cmd_ready
);

    // Offset as seen by the adder
    logic [net_pkg::ddr_addr_bits-1:0] offset_dly;
    net_pkg::mem_cmd_t                 cmd_q;
    logic                              cmd_valid_q;
    logic                              cmd_take;

    if (n_reg_stages == 0) begin : g_no_delay
        assign offset_dly = offset_addr;
    end else begin : g_delay
        // Entry 0 is one cycle old, the last entry feeds the adder
        logic [n_reg_stages-1:0][net_pkg::ddr_addr_bits-1:0] offset_q;

        always_ff @(posedge aclk) begin
            offset_q[0] <= offset_addr;
            for (int i = 1; i < n_reg_stages; i++) begin
                offset_q[i] <= offset_q[i-1];
            end
        end

        assign offset_dly = offset_q[n_reg_stages-1];
    end

    // Register is free when empty or drained in this cycle
    assign s_cmd_ready = !cmd_valid_q || m_cmd_ready;
    assign cmd_take    = s_cmd_valid && s_cmd_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cmd_valid_q <= 1'b0;
        end else if (cmd_take) begin
            cmd_valid_q <= 1'b1;
        end else if (m_cmd_ready) begin
            cmd_valid_q <= 1'b0;
        end
    end

    // Held under back-pressure since it only loads on acceptance
    always_ff @(posedge aclk) begin
        if (cmd_take) begin
            cmd_q.addr <= s_cmd.addr + offset_dly;
            cmd_q.len  <= s_cmd.len;
        end
    end

    assign m_cmd       = cmd_q;
    assign m_cmd_valid = cmd_valid_q;

endmodule

`default_nettype wire

/* net_pkg.sv */
// Network package
// Shared widths, the memory command type and the dropper state type

`default_nettype none

package net_pkg;

    // Stream widths
    localparam int net_data_bits = 64;
    localparam int net_keep_bits = net_data_bits / 8;

    // Packet index and counter width
    localparam int drop_num_bits = 32;

    // Memory command fields
    localparam int ddr_addr_bits = 64;
    localparam int mem_len_bits  = 32;

    // TCP memory command, address in the upper bits
    typedef struct packed {
        logic [ddr_addr_bits-1:0] addr;
        logic [mem_len_bits-1:0]  len;
    } mem_cmd_t;

    // Per-packet state of the dropper
    typedef enum logic [1:0] {
        pkt_first,
        pkt_pass,
        pkt_drop
    } drop_state_t;

endpackage

`default_nettype wire

/* network_top.sv */
// Network top level
// Receive and transmit stream paths with droppers, plus the memory command path

`timescale 1ns/1ns
`default_nettype none

module network_top #(
    parameter int n_reg_stages = 2
) (
    input  logic                              aclk,
    input  logic                              aresetn,

    // Network receive
    input  logic [net_pkg::net_data_bits-1:0] net_rx_tdata,
    input  logic [net_pkg::net_keep_bits-1:0] net_rx_tkeep,
    input  logic                              net_rx_tlast,
    input  logic                              net_rx_tvalid,
    output logic                              net_rx_tready,

    // User receive
    output logic [net_pkg::net_data_bits-1:0] user_rx_tdata,
    output logic [net_pkg::net_keep_bits-1:0] user_rx_tkeep,
    output logic                              user_rx_tlast,
    output logic                              user_rx_tvalid,
    input  logic                              user_rx_tready,

    // User transmit
    input  logic [net_pkg::net_data_bits-1:0] user_tx_tdata,
    input  logic [net_pkg::net_keep_bits-1:0] user_tx_tkeep,
    input  logic                              user_tx_tlast,
    input  logic                              user_tx_tvalid,
    output logic                              user_tx_tready,

    // Network transmit
    output logic [net_pkg::net_data_bits-1:0] net_tx_tdata,
    output logic [net_pkg::net_keep_bits-1:0] net_tx_tkeep,
    output logic                              net_tx_tlast,
    output logic                              net_tx_tvalid,
    input  logic                              net_tx_tready,

    // Drop control
    input  logic                              drop_rx_valid,
    input  logic [net_pkg::drop_num_bits-1:0] drop_rx_num,
    input  logic                              drop_tx_valid,
    input  logic [net_pkg::drop_num_bits-1:0] drop_tx_num,
    input  logic                              clear_drop,

    // Memory commands
    input  logic [net_pkg::ddr_addr_bits-1:0] ddr_offset_addr,
    input  logic [net_pkg::ddr_addr_bits-1:0] mem_cmd_addr,
    input  logic [net_pkg::mem_len_bits-1:0]  mem_cmd_len,
    input  logic                              mem_cmd_valid,
    output logic                              mem_cmd_ready,
    output logic [net_pkg::ddr_addr_bits-1:0] m_mem_cmd_addr,
    output logic [net_pkg::mem_len_bits-1:0]  m_mem_cmd_len,
    output logic                              m_mem_cmd_valid,
    input  logic                              m_mem_cmd_ready
);

    axis_if net_rx ();
    axis_if rx_kept ();
    axis_if user_rx ();
    axis_if user_tx ();
    axis_if tx_sliced ();
    axis_if net_tx ();

    net_pkg::mem_cmd_t s_cmd;
    net_pkg::mem_cmd_t m_cmd;

    // Plain ports onto the local streams
    assign net_rx.tdata   = net_rx_tdata;
    assign net_rx.tkeep   = net_rx_tkeep;
    assign net_rx.tlast   = net_rx_tlast;
    assign net_rx.tvalid  = net_rx_tvalid;
    assign net_rx_tready  = net_rx.tready;

    assign user_rx_tdata  = user_rx.tdata;
    assign user_rx_tkeep  = user_rx.tkeep;
    assign user_rx_tlast  = user_rx.tlast;
    assign user_rx_tvalid = user_rx.tvalid;
    assign user_rx.tready = user_rx_tready;

    assign user_tx.tdata  = user_tx_tdata;
    assign user_tx.tkeep  = user_tx_tkeep;
    assign user_tx.tlast  = user_tx_tlast;
    assign user_tx.tvalid = user_tx_tvalid;
    assign user_tx_tready = user_tx.tready;

    assign net_tx_tdata   = net_tx.tdata;
    assign net_tx_tkeep   = net_tx.tkeep;
    assign net_tx_tlast   = net_tx.tlast;
    assign net_tx_tvalid  = net_tx.tvalid;
    assign net_tx.tready  = net_tx_tready;

    // Receive: drop first, then slice toward the user
    packet_dropper inst_rx_dropper (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s         (net_rx),
        .m         (rx_kept),
        .drop_valid(drop_rx_valid),
        .drop_num  (drop_rx_num),
        .clear_drop(clear_drop)
    );

    axis_slice_array #(.n_reg_stages(n_reg_stages)) inst_rx_slices (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s      (rx_kept),
        .m      (user_rx)
    );

    // Transmit: slice from the user, then drop
    axis_slice_array #(.n_reg_stages(n_reg_stages)) inst_tx_slices (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s      (user_tx),
        .m      (tx_sliced)
    );

    packet_dropper inst_tx_dropper (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s         (tx_sliced),
        .m         (net_tx),
        .drop_valid(drop_tx_valid),
        .drop_num  (drop_tx_num),
        .clear_drop(clear_drop)
    );

    // Memory command path
    assign s_cmd.addr = mem_cmd_addr;
    assign s_cmd.len  = mem_cmd_len;

    mem_cmd_offset #(.n_reg_stages(n_reg_stages)) inst_cmd_offset (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .offset_addr(ddr_offset_addr),
        .s_cmd      (s_cmd),
        .s_cmd_valid(mem_cmd_valid),
        .s_cmd_ready(mem_cmd_ready),
        .m_cmd      (m_cmd),
        .m_cmd_valid(m_mem_cmd_valid),
        .m_cmd_ready(m_mem_cmd_ready)
    );

    assign m_mem_cmd_addr = m_cmd.addr;
    assign m_mem_cmd_len  = m_cmd.len;

endmodule

`default_nettype wire

/* packet_dropper.sv */
// Packet dropper
// Counts packets on one stream and discards the one whose index is armed

`timescale 1ns/1ns
`default_nettype none

module packet_dropper (
    input  logic                              aclk,
    input  logic                              aresetn,
    axis_if.s                                 s,
    axis_if.m                                 m,
    input  logic                              drop_valid,
    input  logic [net_pkg::drop_num_bits-1:0] drop_num,
    input  logic                              clear_drop
);

    net_pkg::drop_state_t              state;
    logic [net_pkg::drop_num_bits-1:0] pkt_cnt;
    logic [net_pkg::drop_num_bits-1:0] drop_idx;
    logic                              drop_armed;
    logic                              dropping;
    logic                              beat_taken;

    // Decision for the current beat, taken at the head of each packet
    always_comb begin
        case (state)
            net_pkg::pkt_first: dropping = drop_armed && (pkt_cnt == drop_idx);
            net_pkg::pkt_drop:  dropping = 1'b1;
            default:            dropping = 1'b0;
        endcase
    end

    // Data path is pure wiring; dropped beats are swallowed
    assign m.tdata  = s.tdata;
    assign m.tkeep  = s.tkeep;
    assign m.tlast  = s.tlast;
    assign m.tvalid = s.tvalid && !dropping;
    assign s.tready = dropping || m.tready;

    assign beat_taken = s.tvalid && s.tready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= net_pkg::pkt_first;
            pkt_cnt    <= '0;
            drop_idx   <= '0;
            drop_armed <= 1'b0;
        end else begin
            if (beat_taken) begin
                if (s.tlast) begin
                    state   <= net_pkg::pkt_first;
                    pkt_cnt <= pkt_cnt + 1'b1;
                    // One programming drops one packet
                    if (dropping) begin
                        drop_armed <= 1'b0;
                    end
                end else begin
                    state <= dropping ? net_pkg::pkt_drop : net_pkg::pkt_pass;
                end
            end

            // Clear restarts counting
            if (clear_drop) begin
                pkt_cnt    <= '0;
                drop_armed <= 1'b0;
            end

            // New index wins over clear in the same cycle
            if (drop_valid) begin
                drop_idx   <= drop_num;
                drop_armed <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_network_top.sv */
// Testbench for the network top level
// Table-driven stream packets with drop control, plus memory commands

`timescale 1ns/1ns
`default_nettype none

module tb_network_top;

    localparam int dw        = net_pkg::net_data_bits;
    localparam int kw        = net_pkg::net_keep_bits;
    localparam int aw        = net_pkg::ddr_addr_bits;
    localparam int lw        = net_pkg::mem_len_bits;
    localparam int beat_bits = dw + kw + 1;
    localparam int n_rows    = 16;
    localparam int max_len   = 8;
    localparam int n_cmds    = 8;

    // Control column of the table
    localparam int ctl_none      = 0;
    localparam int ctl_arm       = 1;
    localparam int ctl_clear     = 2;
    localparam int ctl_clear_arm = 3;

    localparam logic [aw-1:0] ddr_offset = 64'h0000_0040_1000_0000;

    typedef struct {
        int dir;  // 0 receive, 1 transmit
        int len;
        int seed;
        int ctrl;
        int idx;
    } stim_t;

    logic          aclk;
    logic          aresetn;
    logic [dw-1:0] net_rx_tdata;
    logic [kw-1:0] net_rx_tkeep;
    logic          net_rx_tlast;
    logic          net_rx_tvalid;
    logic          net_rx_tready;
    logic [dw-1:0] user_rx_tdata;
    logic [kw-1:0] user_rx_tkeep;
    logic          user_rx_tlast;
    logic          user_rx_tvalid;
    logic          user_rx_tready;
    logic [dw-1:0] user_tx_tdata;
    logic [kw-1:0] user_tx_tkeep;
    logic          user_tx_tlast;
    logic          user_tx_tvalid;
    logic          user_tx_tready;
    logic [dw-1:0] net_tx_tdata;
    logic [kw-1:0] net_tx_tkeep;
    logic          net_tx_tlast;
    logic          net_tx_tvalid;
    logic          net_tx_tready;
    logic          drop_rx_valid;
    logic [31:0]   drop_rx_num;
    logic          drop_tx_valid;
    logic [31:0]   drop_tx_num;
    logic          clear_drop;
    logic [aw-1:0] ddr_offset_addr;
    logic [aw-1:0] mem_cmd_addr;
    logic [lw-1:0] mem_cmd_len;
    logic          mem_cmd_valid;
    logic          mem_cmd_ready;
    logic [aw-1:0] m_mem_cmd_addr;
    logic [lw-1:0] m_mem_cmd_len;
    logic          m_mem_cmd_valid;
    logic          m_mem_cmd_ready;

    stim_t                stim [n_rows];
    logic [beat_bits-1:0] exp_rx [$];
    logic [beat_bits-1:0] exp_tx [$];
    logic [aw+lw-1:0]     exp_cmd [$];
    logic [aw+lw-1:0]     held_cmd;
    logic [aw+lw-1:0]     next_cmd;
    bit                   hold_pending = 1'b0;
    int                   errors = 0;
    int                   bp_seed = 11;

    // Reference dropper state per direction
    int pkt_cnt [2] = '{0, 0};
    int drop_idx [2] = '{0, 0};
    bit armed [2] = '{1'b0, 1'b0};

    network_top #(.n_reg_stages(2)) uut (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic check_val(input string name, input logic [63:0] expv,
                             input logic [63:0] gotv);
        assert (gotv === expv) else begin
            errors++;
            $display("MISMATCH %s expected %h got %h", name, expv, gotv);
        end
    endtask

    task automatic check_beat(input string name, input logic [beat_bits-1:0] expv,
                              input logic [beat_bits-1:0] gotv);
        check_val({name, "_tdata"}, expv[beat_bits-1 -: dw], gotv[beat_bits-1 -: dw]);
        check_val({name, "_tkeep"}, 64'(expv[kw:1]), 64'(gotv[kw:1]));
        check_val({name, "_tlast"}, 64'(expv[0]), 64'(gotv[0]));
    endtask

    // Output ready toggles at random
    always @(posedge aclk) begin
        user_rx_tready  <= ($random(bp_seed) & 3) != 0;
        net_tx_tready   <= ($random(bp_seed) & 3) != 0;
        m_mem_cmd_ready <= ($random(bp_seed) & 1) != 0;
    end

    always @(posedge aclk) begin
        if (aresetn && user_rx_tvalid && user_rx_tready) begin
            assert (exp_rx.size() > 0) else begin
                errors++;
                $display("Beat on user_rx while no receive beat was expected");
            end
            if (exp_rx.size() > 0) begin
                check_beat("user_rx", exp_rx.pop_front(),
                           {user_rx_tdata, user_rx_tkeep, user_rx_tlast});
            end
        end
    end

    always @(posedge aclk) begin
        if (aresetn && net_tx_tvalid && net_tx_tready) begin
            assert (exp_tx.size() > 0) else begin
                errors++;
                $display("Beat on net_tx while no transmit beat was expected");
            end
            if (exp_tx.size() > 0) begin
                check_beat("net_tx", exp_tx.pop_front(),
                           {net_tx_tdata, net_tx_tkeep, net_tx_tlast});
            end
        end
    end

    // Commands must hold while stalled and match on acceptance
    always @(posedge aclk) begin
        if (aresetn && m_mem_cmd_valid) begin
            if (hold_pending) begin
                check_val("m_mem_cmd_addr", held_cmd[aw+lw-1:lw], m_mem_cmd_addr);
                check_val("m_mem_cmd_len", 64'(held_cmd[lw-1:0]), 64'(m_mem_cmd_len));
            end
            if (m_mem_cmd_ready) begin
                hold_pending = 1'b0;
                assert (exp_cmd.size() > 0) else begin
                    errors++;
                    $display("Memory command accepted while none was expected");
                end
                if (exp_cmd.size() > 0) begin
                    next_cmd = exp_cmd.pop_front();
                    check_val("m_mem_cmd_addr", next_cmd[aw+lw-1:lw], m_mem_cmd_addr);
                    check_val("m_mem_cmd_len", 64'(next_cmd[lw-1:0]), 64'(m_mem_cmd_len));
                end
            end else begin
                hold_pending = 1'b1;
                held_cmd     = {m_mem_cmd_addr, m_mem_cmd_len};
            end
        end
    end

    task automatic wait_drain();
        while (exp_rx.size() != 0 || exp_tx.size() != 0 || exp_cmd.size() != 0) begin
            @(posedge aclk);
        end
    endtask

    task automatic pulse_ctrl(input stim_t row);
        @(posedge aclk);
        if (row.ctrl == ctl_clear || row.ctrl == ctl_clear_arm) begin
            clear_drop <= 1'b1;
            pkt_cnt    = '{0, 0};
            armed      = '{1'b0, 1'b0};
        end
        if (row.ctrl == ctl_arm || row.ctrl == ctl_clear_arm) begin
            armed[row.dir]    = 1'b1;
            drop_idx[row.dir] = row.idx;
            if (row.dir == 0) begin
                drop_rx_valid <= 1'b1;
                drop_rx_num   <= row.idx;
            end else begin
                drop_tx_valid <= 1'b1;
                drop_tx_num   <= row.idx;
            end
        end
        @(posedge aclk);
        clear_drop    <= 1'b0;
        drop_rx_valid <= 1'b0;
        drop_tx_valid <= 1'b0;
    endtask

    task automatic drive_beat(input int dir, input logic [beat_bits-1:0] beat);
        if (dir == 0) begin
            {net_rx_tdata, net_rx_tkeep, net_rx_tlast} <= beat;
            net_rx_tvalid <= 1'b1;
            do begin
                @(posedge aclk);
            end while (!net_rx_tready);
        end else begin
            {user_tx_tdata, user_tx_tkeep, user_tx_tlast} <= beat;
            user_tx_tvalid <= 1'b1;
            do begin
                @(posedge aclk);
            end while (!user_tx_tready);
        end
    endtask

    task automatic run_row(input stim_t row);
        logic [beat_bits-1:0] beat;
        logic [kw-1:0]        keep;
        int                   dseed;
        bit                   drop;
        dseed = row.seed;
        // Let earlier packets leave before the counters change
        if (row.ctrl != ctl_none) begin
            wait_drain();
            pulse_ctrl(row);
        end
        drop = armed[row.dir] && (pkt_cnt[row.dir] == drop_idx[row.dir]);
        if (drop) begin
            armed[row.dir] = 1'b0;
        end
        pkt_cnt[row.dir]++;
        @(posedge aclk);
        for (int b = 0; b < row.len; b++) begin
            keep = (b == row.len - 1) ? {kw{1'b1}} >> (row.len % kw) : {kw{1'b1}};
            beat = {$random(dseed), $random(dseed), keep, b == row.len - 1};
            if (!drop && row.dir == 0) begin
                exp_rx.push_back(beat);
            end else if (!drop) begin
                exp_tx.push_back(beat);
            end
            drive_beat(row.dir, beat);
        end
        net_rx_tvalid  <= 1'b0;
        user_tx_tvalid <= 1'b0;
    endtask

    task automatic send_mem_cmds();
        logic [aw-1:0] addr;
        logic [lw-1:0] len;
        int            dseed;
        dseed = 99;
        for (int i = 0; i < n_cmds; i++) begin
            addr = {$random(dseed), $random(dseed)};
            len  = $random(dseed);
            exp_cmd.push_back({addr + ddr_offset, len});
            @(posedge aclk);
            mem_cmd_addr  <= addr;
            mem_cmd_len   <= len;
            mem_cmd_valid <= 1'b1;
            do begin
                @(posedge aclk);
            end while (!mem_cmd_ready);
            mem_cmd_valid <= 1'b0;
        end
    endtask

    initial begin
        // dir, len, seed, control, index
        stim = '{
            '{0, 3,  1, ctl_none,      0},
            '{1, 2,  2, ctl_none,      0},
            '{0, 4,  3, ctl_none,      0},
            '{0, 1,  4, ctl_arm,       2},
            '{0, 5,  5, ctl_none,      0},
            '{1, 3,  6, ctl_arm,       1},
            '{0, 2,  7, ctl_none,      0},
            '{1, 4,  8, ctl_none,      0},
            '{0, 3,  9, ctl_clear,     0},
            '{0, 2, 10, ctl_none,      0},
            '{0, 3, 11, ctl_none,      0},
            '{1, 3, 13, ctl_clear_arm, 0},
            '{1, 2, 14, ctl_none,      0},
            '{0, 4, 15, ctl_arm,       0},
            '{0, 6, 16, ctl_none,      0},
            '{1, 8, 17, ctl_none,      0}
        };
        aresetn         = 1'b0;
        net_rx_tdata    = '0;
        net_rx_tkeep    = '0;
        net_rx_tlast    = 1'b0;
        net_rx_tvalid   = 1'b0;
        user_rx_tready  = 1'b0;
        user_tx_tdata   = '0;
        user_tx_tkeep   = '0;
        user_tx_tlast   = 1'b0;
        user_tx_tvalid  = 1'b0;
        net_tx_tready   = 1'b0;
        drop_rx_valid   = 1'b0;
        drop_rx_num     = '0;
        drop_tx_valid   = 1'b0;
        drop_tx_num     = '0;
        clear_drop      = 1'b0;
        ddr_offset_addr = ddr_offset;
        mem_cmd_addr    = '0;
        mem_cmd_len     = '0;
        mem_cmd_valid   = 1'b0;
        m_mem_cmd_ready = 1'b0;
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            run_row(stim[r]);
        end
        send_mem_cmds();
        wait_drain();
        repeat (10) @(posedge aclk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog scaled to the table size
    initial begin
        repeat (n_rows * max_len * 20 + 500) @(posedge aclk);
        $display("Timeout: traffic did not complete in the allowed number of cycles");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
